// File: verilog/pf_fifo_config.svh
////////////////////////////////////////
// prefetch FIFO configuration
// word width, RAM address width and
// synchronizer depth
////////////////////////////////////////

`ifndef PF_FIFO_CONFIG_SVH
`define PF_FIFO_CONFIG_SVH

// one FIFO word
`define PF_DATA_W 8

// RAM address bits, depth is 2**PF_ADDR_W
`define PF_ADDR_W 11

// flops per cross-domain pointer synchronizer
`define PF_SYNC_STAGES 2

`endif

// File: verilog/pf_fifo_pkg.sv
////////////////////////////////////////
// prefetch FIFO shared types
// widths, RAM port structs, fill enum
////////////////////////////////////////

`include "pf_fifo_config.svh"

package pf_fifo_pkg;

  typedef logic [`PF_DATA_W-1:0] data_t;  // one FIFO word
  typedef logic [`PF_ADDR_W-1:0] addr_t;  // RAM address
  typedef logic [`PF_ADDR_W:0]   ptr_t;   // address plus wrap bit, binary or gray

  typedef struct packed {
    logic  en;    // write strobe
    addr_t addr;
    data_t data;
  } ram_wr_t;

  typedef struct packed {
    logic  en;    // read strobe, output holds when low
    addr_t addr;
  } ram_rd_t;

  // words held or in flight in the prefetch stage
  typedef enum logic [1:0] {FILL_0, FILL_1, FILL_2} pf_fill_e;

endpackage

// File: verilog/pf_dp_ram.sv
////////////////////////////////////////
// simple dual-port RAM
// write on wr_clk, registered read on
// rd_clk
////////////////////////////////////////

`timescale 1ns/1ps
`include "pf_fifo_config.svh"

module pf_dp_ram
  import pf_fifo_pkg::*;
(
  input  logic    wr_clk,
  input  ram_wr_t wr,
  input  logic    rd_clk,
  input  ram_rd_t rd,
  output data_t   rd_data_raw
);

  localparam int DEPTH = 2 ** `PF_ADDR_W;

  data_t mem [DEPTH];  // storage, no reset

  // write port
  always_ff @(posedge wr_clk)
  begin
    if (wr.en)
      mem[wr.addr] <= wr.data;  // store word at write pointer
  end

  // read port, one cycle latency
  always_ff @(posedge rd_clk)
  begin
    if (rd.en)
      rd_data_raw <= mem[rd.addr];  // holds when not enabled
  end

endmodule

// File: verilog/pf_ptr_ctrl.sv
////////////////////////////////////////
// dual-clock pointer controller
// gray pointers crossed both ways,
// registered full and empty flags
////////////////////////////////////////

`timescale 1ns/1ps
`include "pf_fifo_config.svh"

module pf_ptr_ctrl
  import pf_fifo_pkg::*;
(
  input  logic    wr_clk,
  input  logic    wr_rst,
  input  logic    wr_en,
  input  data_t   wr_data,
  output logic    wr_full,
  output ram_wr_t ram_wr,
  input  logic    rd_clk,
  input  logic    rd_rst,
  input  logic    rd_req,
  output logic    rd_empty,
  output ram_rd_t ram_rd
);

  localparam int AW = `PF_ADDR_W;
  localparam int NS = `PF_SYNC_STAGES;

  ptr_t wr_bin, wr_gray;              // write domain pointers
  ptr_t wr_bin_nxt, wr_gray_nxt;
  ptr_t rd_bin, rd_gray;              // read domain pointers
  ptr_t rd_bin_nxt, rd_gray_nxt;
  ptr_t rd_gray_sync_q [NS];          // read gray into wr_clk
  ptr_t wr_gray_sync_q [NS];          // write gray into rd_clk
  ptr_t rd_gray_w, wr_gray_r;         // last synchronizer stage
  logic wr_inc, rd_inc;

  ////////////////////////////////////////
  // write domain
  ////////////////////////////////////////

  assign wr_inc      = wr_en & ~wr_full;            // drop writes while full
  assign wr_bin_nxt  = wr_bin + ptr_t'(wr_inc);
  assign wr_gray_nxt = (wr_bin_nxt >> 1) ^ wr_bin_nxt;
  assign rd_gray_w   = rd_gray_sync_q[NS-1];

  always_ff @(posedge wr_clk or posedge wr_rst)
  begin
    if (wr_rst)
    begin
      wr_bin  <= '0;
      wr_gray <= '0;
      wr_full <= 1'b0;                             // wr_vld high out of reset
    end
    else
    begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt;
      // full when next write pointer laps the read pointer
      wr_full <= (wr_gray_nxt == {~rd_gray_w[AW:AW-1], rd_gray_w[AW-2:0]});
    end
  end

  always_ff @(posedge wr_clk or posedge wr_rst)
  begin
    if (wr_rst)
    begin
      for (int i = 0; i < NS; i++)
        rd_gray_sync_q[i] <= '0;
    end
    else
    begin
      rd_gray_sync_q[0] <= rd_gray;                // first stage may go metastable
      for (int i = 1; i < NS; i++)
        rd_gray_sync_q[i] <= rd_gray_sync_q[i-1];
    end
  end

  assign ram_wr.en   = wr_inc;
  assign ram_wr.addr = wr_bin[AW-1:0];
  assign ram_wr.data = wr_data;                    // straight through

  ////////////////////////////////////////
  // read domain
  ////////////////////////////////////////

  assign rd_inc      = rd_req & ~rd_empty;          // accepted prefetch read
  assign rd_bin_nxt  = rd_bin + ptr_t'(rd_inc);
  assign rd_gray_nxt = (rd_bin_nxt >> 1) ^ rd_bin_nxt;
  assign wr_gray_r   = wr_gray_sync_q[NS-1];

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      rd_bin   <= '0;
      rd_gray  <= '0;
      rd_empty <= 1'b1;
    end
    else
    begin
      rd_bin   <= rd_bin_nxt;
      rd_gray  <= rd_gray_nxt;
      rd_empty <= (rd_gray_nxt == wr_gray_r);      // caught up with writer
    end
  end

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      for (int i = 0; i < NS; i++)
        wr_gray_sync_q[i] <= '0;
    end
    else
    begin
      wr_gray_sync_q[0] <= wr_gray;
      for (int i = 1; i < NS; i++)
        wr_gray_sync_q[i] <= wr_gray_sync_q[i-1];
    end
  end

  assign ram_rd.en   = rd_inc;
  assign ram_rd.addr = rd_bin[AW-1:0];

  // an accepted move never starts from a full or empty position
  a_no_wr_when_full: assert property (@(posedge wr_clk) disable iff (wr_rst)
    wr_inc |-> (wr_gray != {~rd_gray_w[AW:AW-1], rd_gray_w[AW-2:0]}));
  a_no_rd_when_empty: assert property (@(posedge rd_clk) disable iff (rd_rst)
    rd_inc |-> (rd_gray != wr_gray_r));

endmodule

// File: verilog/pf_reg_fifo.sv
////////////////////////////////////////
// two-entry register FIFO
// holds prefetched words, shows head
////////////////////////////////////////

`timescale 1ns/1ps

module pf_reg_fifo
  import pf_fifo_pkg::*;
(
  input  logic  rd_clk,
  input  logic  rd_rst,
  input  logic  in_valid,
  input  data_t in_data,
  input  logic  out_ready,
  output data_t out_data,
  output logic  out_valid
);

  data_t      slot [2];   // payload, no reset
  logic       wr_sel;     // tail slot
  logic       rd_sel;     // head slot
  logic [1:0] cnt;        // words held, 0..2
  logic       pop;

  assign out_valid = (cnt != 2'd0);
  assign out_data  = slot[rd_sel];       // head word, valid with out_valid
  assign pop       = out_valid & out_ready;

  always_ff @(posedge rd_clk)
  begin
    if (in_valid)
      slot[wr_sel] <= in_data;           // capture RAM output
  end

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      wr_sel <= 1'b0;
      rd_sel <= 1'b0;
      cnt    <= 2'd0;
    end
    else
    begin
      if (in_valid)
        wr_sel <= ~wr_sel;
      if (pop)
        rd_sel <= ~rd_sel;
      cnt <= cnt + 2'(in_valid) - 2'(pop);
    end
  end

  // prefetch fill rule keeps a word from arriving when both slots are taken
  a_no_overflow: assert property (@(posedge rd_clk) disable iff (rd_rst)
    in_valid |-> (cnt != 2'd2));

endmodule

// File: verilog/pf_prefetch_fifo.sv
////////////////////////////////////////
// dual-clock FWFT FIFO, 2048 x 8
// RAM, pointer control and a two-word
// prefetch stage on the read side
////////////////////////////////////////

`timescale 1ns/1ps

module pf_prefetch_fifo
  import pf_fifo_pkg::*;
(
  input  logic  wr_clk,
  input  logic  wr_rst,
  input  data_t wr_data,
  input  logic  wr_en,
  output logic  wr_vld,
  input  logic  rd_clk,
  input  logic  rd_rst,
  output data_t rd_data,
  input  logic  rd_en,
  output logic  rd_vld
);

  ram_wr_t  ram_wr;
  ram_rd_t  ram_rd;
  data_t    rd_data_raw;   // RAM output, one cycle after read
  logic     wr_full;
  logic     rd_empty;
  logic     rd_req;        // prefetch read, already gated by empty
  logic     rd_req_q;      // RAM data valid this cycle
  logic     pop;
  pf_fill_e fill_q;

  assign wr_vld = ~wr_full;
  assign pop    = rd_vld & rd_en;

  ////////////////////////////////////////
  // prefetch request and fill tracking
  ////////////////////////////////////////

  // top up while a slot is free, or refill behind a pop
  assign rd_req = ((fill_q != FILL_2) | pop) & ~rd_empty;

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
      rd_req_q <= 1'b0;
    else
      rd_req_q <= rd_req;    // matches RAM read latency
  end

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
      fill_q <= FILL_0;
    else
    begin
      case ({rd_req, pop})
        2'b10:   fill_q <= (fill_q == FILL_0) ? FILL_1 : FILL_2;   // request only
        2'b01:   fill_q <= (fill_q == FILL_2) ? FILL_1 : FILL_0;   // pop only
        default: fill_q <= fill_q;   // both or neither
      endcase
    end
  end

  ////////////////////////////////////////
  // submodules
  ////////////////////////////////////////

  pf_dp_ram u_ram (
    .wr_clk      (wr_clk),
    .wr          (ram_wr),
    .rd_clk      (rd_clk),
    .rd          (ram_rd),
    .rd_data_raw (rd_data_raw)
  );

  pf_ptr_ctrl u_ptr_ctrl (
    .wr_clk   (wr_clk),
    .wr_rst   (wr_rst),
    .wr_en    (wr_en),       // gated by full inside
    .wr_data  (wr_data),
    .wr_full  (wr_full),
    .ram_wr   (ram_wr),
    .rd_clk   (rd_clk),
    .rd_rst   (rd_rst),
    .rd_req   (rd_req),
    .rd_empty (rd_empty),
    .ram_rd   (ram_rd)
  );

  pf_reg_fifo u_reg_fifo (
    .rd_clk    (rd_clk),
    .rd_rst    (rd_rst),
    .in_valid  (rd_req_q),
    .in_data   (rd_data_raw),
    .out_ready (rd_en),
    .out_data  (rd_data),
    .out_valid (rd_vld)
  );

  // a full stage always has its head word on show
  a_fill_cap: assert property (@(posedge rd_clk) disable iff (rd_rst)
    (fill_q == FILL_2) |-> rd_vld);
  // nothing can be shown while the stage is empty
  a_fill_vld: assert property (@(posedge rd_clk) disable iff (rd_rst)
    (fill_q == FILL_0) |-> !rd_vld);

endmodule

// File: verif/pf_fifo_checker.sv
////////////////////////////////////////
// prefetch FIFO checker
// counts writes and pops, compares
// popped words and stall behaviour
////////////////////////////////////////

`timescale 1ns/1ps

module pf_fifo_checker
  import pf_fifo_pkg::*;
(
  input  logic  rd_clk,
  input  logic  rd_rst,
  input  logic  rd_vld,
  input  logic  rd_en,
  input  data_t rd_data,
  input  data_t exp_data,   // reference word for the next pop index
  input  logic  wr_clk,
  input  logic  wr_rst,
  input  logic  wr_en,
  input  logic  wr_vld,
  output int    pop_cnt,
  output int    wr_cnt,
  output int    err_cnt
);

  logic  stall_q;   // last edge saw a head word that was not taken
  data_t held_q;    // head word at that edge

  ////////////////////////////////////////
  // read side
  ////////////////////////////////////////

  always @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      pop_cnt = 0;
      err_cnt = 0;
      stall_q = 1'b0;
    end
    else
    begin
      if (stall_q && rd_vld !== 1'b1)
      begin
        $display("ERR rd_vld under stall: got %h, exp %h", rd_vld, 1'b1);
        err_cnt++;
      end
      else if (stall_q && rd_data !== held_q)
      begin
        $display("ERR rd_data under stall: got %h, exp %h", rd_data, held_q);
        err_cnt++;
      end
      if (rd_vld && rd_en)
      begin
        if (rd_data !== exp_data)   // compare before the index moves on
        begin
          $display("ERR rd_data pop %0d: got %h, exp %h", pop_cnt, rd_data, exp_data);
          err_cnt++;
        end
        pop_cnt++;
      end
      stall_q = rd_vld && !rd_en;
      held_q  = rd_data;
    end
  end

  // write side, accepted words only
  always @(posedge wr_clk or posedge wr_rst)
  begin
    if (wr_rst)
      wr_cnt = 0;
    else if (wr_en && wr_vld)
      wr_cnt++;
  end

endmodule

// File: verif/tb_pf_prefetch_fifo.sv
////////////////////////////////////////
// testbench for the dual-clock
// prefetch FIFO
////////////////////////////////////////

`timescale 1ns/1ps

module tb_pf_prefetch_fifo
  import pf_fifo_pkg::*;
();

  localparam int N_WORDS  = 3000;     // random traffic phase
  localparam int FULL_CAP = 2050;     // RAM depth plus two prefetched words
  localparam int N_DROP   = 20;
  localparam int N_TAIL   = 40;
  localparam int N_PROBE  = 16;       // rd_en high cycles on a drained FIFO
  localparam int WAIT_MAX = 500;      // cycles for one flag wait
  localparam int BULK_MAX = 50000;    // cycles for one bulk transfer
  localparam int RUN_MAX  = 100000;   // rd_clk cycles for the whole run

  logic  wr_clk, wr_rst, wr_en, wr_vld;
  logic  rd_clk, rd_rst, rd_en, rd_vld;
  data_t wr_data, rd_data, exp_pop;
  int    pop_cnt, wr_cnt, chk_errs;
  int    tb_errs;
  int    n_wr;        // index of the next word to write
  int    base;
  bit    timed_out;
  bit    run_done;

  // word n of the stream, index bits mixed so wraps show up
  function automatic data_t expected_word(input int n);
    logic [31:0] x;
    x = n * 32'h9E37_79B1;
    return x[31:24] ^ x[7:0] ^ 8'h3C;
  endfunction

  assign exp_pop = expected_word(pop_cnt);

  pf_prefetch_fifo dut (
    .wr_clk (wr_clk), .wr_rst (wr_rst), .wr_data (wr_data), .wr_en (wr_en), .wr_vld (wr_vld),
    .rd_clk (rd_clk), .rd_rst (rd_rst), .rd_data (rd_data), .rd_en (rd_en), .rd_vld (rd_vld)
  );

  pf_fifo_checker u_chk (
    .rd_clk (rd_clk), .rd_rst (rd_rst), .rd_vld (rd_vld), .rd_en (rd_en),
    .rd_data (rd_data), .exp_data (exp_pop),
    .wr_clk (wr_clk), .wr_rst (wr_rst), .wr_en (wr_en), .wr_vld (wr_vld),
    .pop_cnt (pop_cnt), .wr_cnt (wr_cnt), .err_cnt (chk_errs)
  );

  initial
  begin
    rd_clk = 1'b0;
    forever #20 rd_clk = ~rd_clk;   // 40 ns
  end

  initial
  begin
    wr_clk = 1'b0;
    forever #14 wr_clk = ~wr_clk;   // 28 ns, unrelated to rd_clk
  end

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERR %s: got %h, exp %h", name, got, exp);
      tb_errs++;
    end
  endtask

  task automatic check_int(input string name, input int got, input int exp);
    if (got != exp)
    begin
      $display("ERR %s: got %h, exp %h", name, got, exp);
      tb_errs++;
    end
  endtask

  task automatic give_up(input string what);
    $display("Timeout: %s", what);
    timed_out = 1'b1;
    run_done  = 1'b1;
  endtask

  // words go out only while wr_vld is high, so each one is accepted
  task automatic write_words(input int count, input int max_gap, input bit until_full);
    int sent;
    int gap;
    int stall;
    sent  = 0;
    gap   = 0;
    stall = 0;
    while (sent < count && !run_done)
    begin
      @(negedge wr_clk);
      wr_en = 1'b0;
      if (until_full && !wr_vld)
        break;                      // full reached
      if (gap > 0)
        gap--;
      else if (wr_vld)
      begin
        wr_en   = 1'b1;
        wr_data = expected_word(n_wr);
        n_wr++;
        sent++;
        gap   = $urandom % (max_gap + 1);
        stall = 0;
      end
      else
      begin
        stall++;
        if (stall > WAIT_MAX)
          give_up("wr_vld stayed low while words were waiting to be written");
      end
    end
    if (wr_en)
    begin
      @(negedge wr_clk);
      wr_en = 1'b0;
    end
  endtask

  // pop at random until the checker has seen target words
  task automatic read_until(input int target);
    int cyc;
    cyc = 0;
    while (pop_cnt < target && !run_done)
    begin
      @(negedge rd_clk);
      rd_en = (pop_cnt < target) && ($urandom % 4 != 0);
      cyc++;
      if (cyc > BULK_MAX)
        give_up("the read side stopped delivering words");
    end
    rd_en = 1'b0;
  endtask

  // rd_en held high on a drained FIFO so any stray word gets popped and counted
  task automatic probe_extra_pops(input int cycles);
    repeat (cycles)
    begin
      @(negedge rd_clk);
      rd_en = 1'b1;
    end
    @(negedge rd_clk);
    rd_en = 1'b0;
  endtask

  task automatic wait_rd_vld(input logic level, input string what);
    int cyc;
    cyc = 0;
    while (rd_vld !== level && !run_done)
    begin
      @(negedge rd_clk);
      cyc++;
      if (cyc > WAIT_MAX)
        give_up(what);
    end
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial
  begin
    void'($urandom(21981));
    wr_rst  = 1'b1;
    rd_rst  = 1'b1;
    wr_en   = 1'b0;
    wr_data = '0;
    rd_en   = 1'b0;
    n_wr    = 0;
    tb_errs = 0;
    repeat (10)
    begin
      @(negedge rd_clk);
      check_bit("rd_vld", rd_vld, 1'b0);   // flags held in reset
      check_bit("wr_vld", wr_vld, 1'b1);
    end
    rd_rst = 1'b0;
    @(negedge wr_clk);
    wr_rst = 1'b0;
    repeat (4)
    begin
      @(negedge rd_clk);
      check_bit("rd_vld", rd_vld, 1'b0);
      check_bit("wr_vld", wr_vld, 1'b1);
    end
    fork
      write_words(N_WORDS, 3, 1'b0);
      read_until(N_WORDS);
    join
    probe_extra_pops(N_PROBE);
    check_int("pop_cnt", pop_cnt, wr_cnt);
    // reads stalled, two words prefetched, then fill the RAM
    base = wr_cnt;
    write_words(2, 0, 1'b0);
    wait_rd_vld(1'b1, "rd_vld never rose after the first two words");
    write_words(BULK_MAX, 0, 1'b1);
    check_int("wr_cnt", wr_cnt - base, FULL_CAP);
    // held writes while full must be dropped
    base = wr_cnt;
    repeat (N_DROP)
    begin
      @(negedge wr_clk);
      wr_en   = 1'b1;
      wr_data = expected_word(n_wr) ^ 8'hFF;   // never the next valid word
      check_bit("wr_vld", wr_vld, 1'b0);
    end
    @(negedge wr_clk);
    wr_en = 1'b0;
    check_int("wr_cnt", wr_cnt, base);
    read_until(wr_cnt);
    fork
      write_words(N_TAIL, 2, 1'b0);   // sequence picks up after the drops
      read_until(wr_cnt + N_TAIL);
    join
    probe_extra_pops(N_PROBE);
    check_int("pop_cnt", pop_cnt, wr_cnt);
    wait_rd_vld(1'b0, "rd_vld stayed high after the last word was popped");
    repeat (20)
    begin
      @(negedge rd_clk);
      check_bit("rd_vld", rd_vld, 1'b0);
    end
    run_done = 1'b1;
  end

  // closing report
  initial
  begin
    int cyc;
    bit late;
    cyc  = 0;
    late = 1'b0;
    while (!run_done && cyc < RUN_MAX)
    begin
      @(posedge rd_clk or posedge run_done);
      cyc++;
    end
    if (!run_done)
    begin
      $display("Timeout: the run did not complete");
      late = 1'b1;
    end
    $display("writes %0d, pops %0d, checker errors %0d, tb errors %0d",
             wr_cnt, pop_cnt, chk_errs, tb_errs);
    if (tb_errs == 0 && chk_errs == 0 && !timed_out && !late)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: src.f
+incdir+verilog
verilog/pf_fifo_pkg.sv
verilog/pf_dp_ram.sv
verilog/pf_ptr_ctrl.sv
verilog/pf_reg_fifo.sv
verilog/pf_prefetch_fifo.sv
verif/pf_fifo_checker.sv
verif/tb_pf_prefetch_fifo.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the prefetch FIFO testbench with Verilator
# exit status is zero only when the pass line is found

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f \
  --top-module tb_pf_prefetch_fifo -o sim_tb || { echo "build failed"; exit 1; }

out="$(./obj_dir/sim_tb)"
echo "$out"
echo "$out" | grep -qx "Simulation passed" && exit 0 || exit 1
